// File: common/core_defs.svh
/*
 * Core sizing macros for the PRF and the integer datapath.
 * Include wherever bank, register or data widths are needed.
 */

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// banked physical register file
`define PRF_BANK_COUNT 4
`define LOG_PRF_BANK_COUNT 2

// physical register namespace
`define PR_COUNT 64
`define LOG_PR_COUNT 6

// integer datapath width
`define XLEN 32

`endif

// File: common/core_types_pkg.sv
/*
 * Shared types for the ALU execution pipeline.
 * Opcode encoding, issue and PRF reply bundles, writeback bundle
 * and the collected operand record. Referenced by scoped names.
 */

`include "core_defs.svh"

package core_types_pkg;

	// funct3 order in the low bits, bit 3 picks SUB / SRA
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101,
		// passes operand B straight through
		ALU_LUI  = 4'b1111
	} alu_op_t;

	// one operation from the ALU issue queue
	typedef struct packed {
		logic valid;
		alu_op_t op;
		logic is_imm;
		logic [31:0] imm;
		logic A_unneeded;
		logic A_forward;
		logic [`LOG_PRF_BANK_COUNT-1:0] A_bank;
		logic B_forward;
		logic [`LOG_PRF_BANK_COUNT-1:0] B_bank;
		logic [`LOG_PR_COUNT-1:0] dest_PR;
	} alu_issue_t;

	// read reply from the PRF
	// the per-operand valid also strobes the forward word for a forwarded operand
	typedef struct packed {
		logic A_reg_read_valid;
		logic B_reg_read_valid;
		logic [`PRF_BANK_COUNT-1:0][`XLEN-1:0] data_by_bank;
	} prf_read_t;

	// forward bus from the PRF, one word per bank
	typedef struct packed {
		logic [`PRF_BANK_COUNT-1:0][`XLEN-1:0] data_by_bank;
	} prf_forward_t;

	// result back to the PRF
	typedef struct packed {
		logic WB_valid;
		logic [`XLEN-1:0] WB_data;
		logic [`LOG_PR_COUNT-1:0] WB_PR;
	} alu_wb_t;

	// operand as held by the collect stage
	typedef struct packed {
		logic present;
		logic [`XLEN-1:0] value;
	} operand_t;

endpackage

// File: alu_pipeline/alu_operand_select.sv
/*
 * Operand source select for the collect stage.
 * Keeps a saved operand or picks up the bank word from a register-read
 * reply or the forward bus. One instance per source operand.
 */

`timescale 1ns/1ps
`include "core_defs.svh"

module alu_operand_select (
	input logic [`LOG_PRF_BANK_COUNT-1:0] bank,
	input logic forward,
	input logic first_cycle,
	input logic reg_read_valid,
	input core_types_pkg::prf_read_t reg_read,
	input core_types_pkg::prf_forward_t fwd,
	input core_types_pkg::operand_t saved,
	output core_types_pkg::operand_t operand
);

	// bank words for this operand's bank
	logic [`XLEN-1:0] read_word;
	logic [`XLEN-1:0] fwd_word;

	assign read_word = reg_read.data_by_bank[bank];
	assign fwd_word = fwd.data_by_bank[bank];

	// --------------------------------------------------
	// source priority

	always_comb begin
		// default holds whatever was collected so far
		operand = saved;
		if (!saved.present) begin
			if (forward) begin
				// forwarded operand can land in any collect cycle
				if (reg_read_valid) begin
					operand.present = 1'b1;
					operand.value = fwd_word;
				end
			end
			else if (first_cycle && reg_read_valid) begin
				// read reply only counts in the first collect cycle
				operand.present = 1'b1;
				operand.value = read_word;
			end
		end
	end

endmodule

// File: alu_pipeline/alu_exec.sv
/*
 * Combinational RISC-V integer ALU.
 * Covers the ten register ops and a pass-B for LUI.
 */

`timescale 1ns/1ps
`include "core_defs.svh"

module alu_exec (
	input core_types_pkg::alu_op_t op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result
);

	// shift amount is the low 5 bits only
	logic [4:0] shamt;

	// compare flags
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = b[4:0];
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	// --------------------------------------------------
	// op decode

	always_comb begin
		case (op)
			core_types_pkg::ALU_ADD: begin
				result = a + b;
			end
			core_types_pkg::ALU_SUB: begin
				result = a - b;
			end
			core_types_pkg::ALU_SLL: begin
				result = a << shamt;
			end
			core_types_pkg::ALU_SLT: begin
				result = {{(`XLEN-1){1'b0}}, lt_signed};
			end
			core_types_pkg::ALU_SLTU: begin
				result = {{(`XLEN-1){1'b0}}, lt_unsigned};
			end
			core_types_pkg::ALU_XOR: begin
				result = a ^ b;
			end
			core_types_pkg::ALU_SRL: begin
				result = a >> shamt;
			end
			core_types_pkg::ALU_SRA: begin
				// arithmetic, sign fills from the top
				result = $unsigned($signed(a) >>> shamt);
			end
			core_types_pkg::ALU_OR: begin
				result = a | b;
			end
			core_types_pkg::ALU_AND: begin
				result = a & b;
			end
			core_types_pkg::ALU_LUI: begin
				result = b;
			end
			default: begin
				// unused encodings read as zero
				result = '0;
			end
		endcase
	end

endmodule

// File: alu_pipeline/alu_pipeline.sv
/*
 * Integer ALU pipeline, a collect stage then a writeback register.
 * Takes one op when ready is high, waits for both operands, then
 * writes the result back the cycle after they are all present.
 */

`timescale 1ns/1ps
`include "core_defs.svh"

module alu_pipeline (
	input logic CLK,
	input logic nRST,
	input core_types_pkg::alu_issue_t issue,
	input core_types_pkg::prf_read_t reg_read,
	input core_types_pkg::prf_forward_t fwd,
	output logic ready,
	output core_types_pkg::alu_wb_t wb
);

	// what the collect stage keeps of an issued op
	// imm and A_unneeded are folded into the saved operands at accept
	typedef struct packed {
		core_types_pkg::alu_op_t op;
		logic A_forward;
		logic [`LOG_PRF_BANK_COUNT-1:0] A_bank;
		logic B_forward;
		logic [`LOG_PRF_BANK_COUNT-1:0] B_bank;
		logic [`LOG_PR_COUNT-1:0] dest_PR;
	} collect_t;

	// collect stage control
	logic collect_valid;
	logic collect_first;
	logic collect_done;
	logic accept;

	// collect stage payload
	collect_t collect_op;
	core_types_pkg::operand_t saved_A;
	core_types_pkg::operand_t saved_B;

	// operands after this cycle's pickup
	core_types_pkg::operand_t operand_A;
	core_types_pkg::operand_t operand_B;

	logic [`XLEN-1:0] exec_result;

	// writeback register
	logic wb_valid;
	logic [`XLEN-1:0] wb_data;
	logic [`LOG_PR_COUNT-1:0] wb_pr;

	// --------------------------------------------------
	// handshake

	// op finishes collecting once both operands are in
	assign collect_done = collect_valid & operand_A.present & operand_B.present;

	// free slot, or the current op leaves at this edge
	assign ready = ~collect_valid | collect_done;
	assign accept = issue.valid & ready;

	// --------------------------------------------------
	// operand pickup and execute

	alu_operand_select operand_A_select (
		.bank(collect_op.A_bank),
		.forward(collect_op.A_forward),
		.first_cycle(collect_first),
		.reg_read_valid(reg_read.A_reg_read_valid),
		.reg_read(reg_read),
		.fwd(fwd),
		.saved(saved_A),
		.operand(operand_A)
	);

	alu_operand_select operand_B_select (
		.bank(collect_op.B_bank),
		.forward(collect_op.B_forward),
		.first_cycle(collect_first),
		.reg_read_valid(reg_read.B_reg_read_valid),
		.reg_read(reg_read),
		.fwd(fwd),
		.saved(saved_B),
		.operand(operand_B)
	);

	alu_exec alu_exec_inst (
		.op(collect_op.op),
		.a(operand_A.value),
		.b(operand_B.value),
		.result(exec_result)
	);

	// --------------------------------------------------
	// collect stage

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			collect_valid <= 1'b0;
			collect_first <= 1'b0;
		end
		else begin
			// a new op may drop in the same edge the old one leaves
			collect_valid <= accept | (collect_valid & ~collect_done);
			collect_first <= accept;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			collect_op.op <= issue.op;
			collect_op.A_forward <= issue.A_forward;
			collect_op.A_bank <= issue.A_bank;
			collect_op.B_forward <= issue.B_forward;
			collect_op.B_bank <= issue.B_bank;
			collect_op.dest_PR <= issue.dest_PR;
			// A reads as zero when the op has no A source
			saved_A.present <= issue.A_unneeded;
			saved_A.value <= '0;
			// immediate stands in for B
			saved_B.present <= issue.is_imm;
			saved_B.value <= issue.imm;
		end
		else begin
			// keep whatever arrived this cycle
			saved_A <= operand_A;
			saved_B <= operand_B;
		end
	end

	// --------------------------------------------------
	// writeback stage

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_valid <= 1'b0;
		end
		else begin
			// single-cycle pulse per completed op
			wb_valid <= collect_done;
		end
	end

	always_ff @(posedge CLK) begin
		if (collect_done) begin
			wb_data <= exec_result;
			wb_pr <= collect_op.dest_PR;
		end
	end

	assign wb.WB_valid = wb_valid;
	assign wb.WB_data = wb_data;
	assign wb.WB_PR = wb_pr;

endmodule

// File: alu_pipeline/alu_pipeline_wrapper.sv
/*
 * Top level around the ALU pipeline.
 * Flops every pipeline input and output once, so the queue sees
 * ready one cycle late and writeback one cycle after the pipeline.
 */

`timescale 1ns/1ps

module alu_pipeline_wrapper (
	input logic CLK,
	input logic nRST,
	input core_types_pkg::alu_issue_t next_issue,
	input core_types_pkg::prf_read_t next_reg_read,
	input core_types_pkg::prf_forward_t next_forward,
	output logic last_ready,
	output core_types_pkg::alu_wb_t last_wb
);

	// pipeline side of the input flops
	core_types_pkg::alu_issue_t issue;
	core_types_pkg::prf_read_t reg_read;
	core_types_pkg::prf_forward_t fwd;

	// pipeline side of the output flops
	logic ready;
	core_types_pkg::alu_wb_t wb;

	alu_pipeline alu_pipeline_inst (
		.CLK(CLK),
		.nRST(nRST),
		.issue(issue),
		.reg_read(reg_read),
		.fwd(fwd),
		.ready(ready),
		.wb(wb)
	);

	// --------------------------------------------------
	// boundary flops

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			issue <= '0;
			reg_read <= '0;
			fwd <= '0;
			// queue may issue straight out of reset
			last_ready <= 1'b1;
			last_wb <= '0;
		end
		else begin
			issue <= next_issue;
			reg_read <= next_reg_read;
			fwd <= next_forward;
			last_ready <= ready;
			last_wb <= wb;
		end
	end

endmodule

// File: tb/alu_pipeline_assert.sv
/*
 * Concurrent checks on the ALU pipeline, bound into every alu_pipeline.
 * Failures go out through $error and are counted for the testbench.
 */

`timescale 1ns/1ps

module alu_pipeline_assert (
	input logic CLK,
	input logic nRST,
	input logic issue_valid,
	input logic ready,
	input logic collect_done,
	input logic wb_valid
);

	// read by the testbench at the end of the run
	int fail_count = 0;

	// writeback register is held clear while reset is asserted
	wb_low_in_reset: assert property (@(posedge CLK) !nRST |-> !wb_valid)
	else begin
		fail_count = fail_count + 1;
		$error("writeback valid while reset is asserted");
	end

	// an issue seen while the collect stage is stalled would be dropped
	issue_needs_ready: assert property (@(posedge CLK) disable iff (!nRST)
		issue_valid |-> ready)
	else begin
		fail_count = fail_count + 1;
		$error("issue valid while pipeline ready is low");
	end

	// each writeback pulse comes from a completion one cycle earlier
	wb_after_done: assert property (@(posedge CLK) disable iff (!nRST)
		wb_valid |-> $past(collect_done))
	else begin
		fail_count = fail_count + 1;
		$error("writeback valid without a collect completion");
	end

endmodule

bind alu_pipeline alu_pipeline_assert alu_pipeline_assert_inst (
	.CLK(CLK),
	.nRST(nRST),
	.issue_valid(issue.valid),
	.ready(ready),
	.collect_done(collect_done),
	.wb_valid(wb.WB_valid)
);

// File: tb/alu_pipeline_tb.sv
/*
 * Testbench for the registered ALU pipeline top level.
 * Plays the issue queue and the PRF from the stim file, checks every
 * writeback in issue order against the expected column.
 */

`timescale 1ns/1ps
`include "core_defs.svh"

module alu_pipeline_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_OPS = 64;
	localparam int FIELDS = 11;

	// stim file columns
	localparam int F_OP = 0;
	localparam int F_IS_IMM = 1;
	localparam int F_IMM = 2;
	localparam int F_A = 3;
	localparam int F_B = 4;
	localparam int F_A_SRC = 5;
	localparam int F_B_SRC = 6;
	localparam int F_A_BANK = 7;
	localparam int F_B_BANK = 8;
	localparam int F_PR = 9;
	localparam int F_EXP = 10;

	// forward source codes carry the wait cycles in their offset from SRC_FWD0
	localparam int SRC_UNNEEDED = 1;
	localparam int SRC_FWD0 = 2;

	// one outstanding operation in the scoreboard
	typedef struct packed {
		logic [31:0] index;
		logic [31:0] result;
		logic [`LOG_PR_COUNT-1:0] dest_pr;
		logic [31:0] issue_cycle;
		logic [1:0] wait_cycles;
		logic [31:0] low_mark;
	} expect_t;

	logic CLK = 1'b0;
	logic nRST;
	core_types_pkg::alu_issue_t next_issue;
	core_types_pkg::prf_read_t next_reg_read;
	core_types_pkg::prf_forward_t next_forward;
	logic last_ready;
	core_types_pkg::alu_wb_t last_wb;

	logic [31:0] stim_mem [0:MAX_OPS*FIELDS-1];
	integer seed = 32'h0913726c;
	int n_ops = 0;
	int cycle = 0;
	int low_count = 0;
	expect_t sb[$];

	alu_pipeline_wrapper alu_pipeline_wrapper_inst (
		.CLK(CLK),
		.nRST(nRST),
		.next_issue(next_issue),
		.next_reg_read(next_reg_read),
		.next_forward(next_forward),
		.last_ready(last_ready),
		.last_wb(last_wb)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	always @(posedge CLK) begin
		cycle <= cycle + 1;
	end

	// --------------------------------------------------
	// checking helpers

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s, got %08h expected %08h", $time, what, actual,
				expected);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("*** FAILED ***");
		$fatal(1, "run aborted");
	endtask

	// --------------------------------------------------
	// PRF stand-in

	// true when this operand's word goes out in reply cycle t
	function automatic logic strobes_now(input int src, input int t);
		if (src < SRC_FWD0) begin
			return t == 0;
		end
		return (src - SRC_FWD0) == t;
	endfunction

	task automatic fill_random_banks(output core_types_pkg::prf_read_t rr,
		output core_types_pkg::prf_forward_t fw);
		rr = '0;
		fw = '0;
		for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
			rr.data_by_bank[b] = $random(seed);
			fw.data_by_bank[b] = $random(seed);
		end
	endtask

	// reply for cycle t after issue with random words outside the named banks
	task automatic build_reply(input int base, input int t,
		output core_types_pkg::prf_read_t rr, output core_types_pkg::prf_forward_t fw);
		int a_src;
		int b_src;
		logic [1:0] a_bank;
		logic [1:0] b_bank;
		a_src = stim_mem[base + F_A_SRC];
		b_src = stim_mem[base + F_B_SRC];
		a_bank = stim_mem[base + F_A_BANK][1:0];
		b_bank = stim_mem[base + F_B_BANK][1:0];
		fill_random_banks(rr, fw);
		// unneeded A and imm B still get a valid word, which must be ignored
		if (strobes_now(a_src, t)) begin
			rr.A_reg_read_valid = 1'b1;
			if (a_src >= SRC_FWD0)
				fw.data_by_bank[a_bank] = stim_mem[base + F_A];
			else
				rr.data_by_bank[a_bank] = stim_mem[base + F_A];
		end
		if (strobes_now(b_src, t)) begin
			rr.B_reg_read_valid = 1'b1;
			if (b_src >= SRC_FWD0)
				fw.data_by_bank[b_bank] = stim_mem[base + F_B];
			else
				rr.data_by_bank[b_bank] = stim_mem[base + F_B];
		end
	endtask

	// --------------------------------------------------
	// issue queue stand-in

	task automatic run_operation(input int idx);
		int base;
		int a_src;
		int b_src;
		int w;
		int t;
		core_types_pkg::alu_issue_t iss;
		core_types_pkg::prf_read_t rr;
		core_types_pkg::prf_forward_t fw;
		expect_t entry;
		base = idx * FIELDS;
		a_src = stim_mem[base + F_A_SRC];
		b_src = stim_mem[base + F_B_SRC];
		// longest forward wait decides how long the reply phase runs
		w = 0;
		if (a_src >= SRC_FWD0)
			w = a_src - SRC_FWD0;
		if (b_src >= SRC_FWD0 && b_src - SRC_FWD0 > w)
			w = b_src - SRC_FWD0;
		iss = '0;
		iss.valid = 1'b1;
		iss.op = core_types_pkg::alu_op_t'(stim_mem[base + F_OP][3:0]);
		iss.is_imm = stim_mem[base + F_IS_IMM][0];
		iss.imm = stim_mem[base + F_IMM];
		iss.A_unneeded = (a_src == SRC_UNNEEDED);
		iss.A_forward = (a_src >= SRC_FWD0);
		iss.A_bank = stim_mem[base + F_A_BANK][1:0];
		iss.B_forward = (b_src >= SRC_FWD0);
		iss.B_bank = stim_mem[base + F_B_BANK][1:0];
		iss.dest_PR = stim_mem[base + F_PR][`LOG_PR_COUNT-1:0];
		@(posedge CLK);
		while (last_ready !== 1'b1) begin
			@(posedge CLK);
		end
		fill_random_banks(rr, fw);
		next_issue <= iss;
		next_reg_read <= rr;
		next_forward <= fw;
		entry.index = idx;
		entry.result = stim_mem[base + F_EXP];
		entry.dest_pr = iss.dest_PR;
		entry.issue_cycle = cycle;
		entry.wait_cycles = w[1:0];
		entry.low_mark = low_count;
		sb.push_back(entry);
		// read reply goes out one cycle after issue and forwards up to w cycles later
		for (t = 0; t <= w; t++) begin
			@(posedge CLK);
			build_reply(base, t, rr, fw);
			next_issue <= '0;
			next_reg_read <= rr;
			next_forward <= fw;
		end
	endtask

	// --------------------------------------------------
	// writeback monitor and scoreboard

	task automatic check_writeback();
		expect_t entry;
		logic [31:0] latency;
		if (sb.size() == 0) begin
			abort_run("writeback arrived with no operation outstanding");
		end
		else begin
			entry = sb.pop_front();
			latency = cycle - entry.issue_cycle - 1;
			check_value(last_wb.WB_data, entry.result, $sformatf("op %0d result", entry.index));
			check_value(last_wb.WB_PR, entry.dest_pr, $sformatf("op %0d dest PR", entry.index));
			check_value(latency, 4 + entry.wait_cycles,
				$sformatf("op %0d issue to writeback cycles", entry.index));
			// a forward wait has to show up as a stall on last_ready
			if (entry.wait_cycles != 0)
				check_value(low_count != entry.low_mark, 1,
					$sformatf("op %0d last_ready drop while waiting", entry.index));
		end
	endtask

	always @(posedge CLK) begin
		if (nRST === 1'b1) begin
			if (last_ready === 1'b0)
				low_count <= low_count + 1;
			if (last_wb.WB_valid)
				check_writeback();
		end
	end

	// stop if writebacks dry up
	initial begin
		wait (n_ops > 0);
		#((n_ops * 12 + RESET_CYCLES) * CLK_PERIOD);
		$display("ERROR: timeout, writebacks stopped arriving with %0d outstanding",
			sb.size());
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	// --------------------------------------------------
	// main sequence

	initial begin
		int drain;
		nRST = 1'b0;
		next_issue = '0;
		next_reg_read = '0;
		next_forward = '0;
		$readmemh("tb/alu_pipeline_stim.txt", stim_mem);
		while (n_ops < MAX_OPS && stim_mem[n_ops * FIELDS + F_EXP] !== 32'bx)
			n_ops++;
		if (n_ops == 0) begin
			abort_run("no operations found in the stimulus file");
		end
		else begin
			$display("loaded %0d operations", n_ops);
			repeat (RESET_CYCLES) @(posedge CLK);
			nRST <= 1'b1;
			// idle state straight after reset
			repeat (2) @(posedge CLK);
			check_value(last_ready, 1, "last_ready after reset");
			check_value(last_wb.WB_valid, 0, "last_wb valid after reset");
			for (int i = 0; i < n_ops; i++)
				run_operation(i);
			// last op needs at most 4 cycles plus 3 forward waits
			drain = 0;
			while (sb.size() != 0 && drain < 12) begin
				@(posedge CLK);
				drain++;
			end
			check_value(sb.size(), 0, "operations still outstanding");
			// extra cycles catch a duplicated writeback
			repeat (8) @(posedge CLK);
			check_value(last_ready, 1, "last_ready after the last operation");
			if (alu_pipeline_wrapper_inst.alu_pipeline_inst.alu_pipeline_assert_inst.fail_count
				== 0) begin
				$display("*** PASSED ***");
				$finish;
			end
			else begin
				$display("ERROR: bound assertions reported failures");
				$display("*** FAILED ***");
				$fatal(1, "assertion failures");
			end
		end
	end

endmodule

// File: tb/alu_pipeline_stim.txt
// columns: op is_imm imm a_val b_val a_src b_src a_bank b_bank dest_pr expected
// src codes: 0 reg read, 1 unneeded or imm, 2..5 forward after 0..3 wait cycles
0 0 00000000 00000005 00000007 0 0 0 1 01 0000000c
0 0 00000000 ffffffff 00000001 0 0 2 3 02 00000000
8 0 00000000 00000003 00000005 0 0 1 0 03 fffffffe
8 0 00000000 80000000 00000001 0 0 3 2 04 7fffffff
1 0 00000000 00000001 0000001f 0 0 0 2 05 80000000
1 0 00000000 00000003 00000024 0 0 1 3 06 00000030
2 0 00000000 ffffffff 00000001 0 0 0 1 07 00000001
2 0 00000000 00000001 ffffffff 0 0 2 3 08 00000000
2 0 00000000 80000000 7fffffff 0 0 3 0 09 00000001
3 0 00000000 ffffffff 00000001 0 0 0 1 0a 00000000
3 0 00000000 00000001 ffffffff 0 0 1 2 0b 00000001
3 0 00000000 12345678 12345678 0 0 2 2 0c 00000000
4 0 00000000 f0f0f0f0 ff00ff00 0 0 3 1 0d 0ff00ff0
5 0 00000000 80000000 0000001f 0 0 0 3 0e 00000001
5 0 00000000 f0000000 00000044 0 0 2 1 0f 0f000000
d 0 00000000 80000000 0000001f 0 0 1 0 10 ffffffff
d 0 00000000 f0000000 00000024 0 0 3 2 11 ff000000
d 0 00000000 7ffffff0 00000004 0 0 0 1 12 07ffffff
6 0 00000000 00ff00ff 0f0f0f0f 0 0 2 0 13 0fff0fff
7 0 00000000 00ff00ff 0f0f0f0f 0 0 1 3 14 000f000f
f 0 00000000 deadbeef 12345000 1 0 0 1 15 12345000
0 1 fffffff0 00000020 55555555 0 1 2 3 16 00000010
4 1 000000ff 0000ff0f aaaaaaaa 0 1 0 1 17 0000fff0
3 1 00000001 00000000 00000000 0 1 3 0 18 00000001
d 1 00000008 80000000 00000000 0 1 1 2 19 ff800000
f 1 abcde000 11111111 22222222 1 1 2 3 1a abcde000
0 0 00000000 7fffffff 00000042 1 0 0 1 1b 00000042
0 0 00000000 00000100 00000023 2 0 1 2 1c 00000123
8 0 00000000 00001000 00000001 0 3 0 3 1d 00000fff
6 0 00000000 f0000000 0000000f 4 0 2 0 1e f000000f
7 0 00000000 ffff0000 0ff00ff0 5 3 3 1 1f 0ff00000
4 0 00000000 12345678 ffffffff 4 4 0 1 20 edcba987
0 1 00000001 7fffffff 00000000 5 1 2 0 21 80000000
0 0 00000000 00000001 00000002 0 0 3 2 22 00000003
8 0 00000000 00000010 00000001 0 0 2 1 23 0000000f
1 0 00000000 0000000f 00000008 0 0 1 0 24 00000f00
4 0 00000000 aaaaaaaa 55555555 0 0 0 3 3f ffffffff

// File: tb.f
+incdir+common
common/core_types_pkg.sv
alu_pipeline/alu_operand_select.sv
alu_pipeline/alu_exec.sv
alu_pipeline/alu_pipeline.sv
alu_pipeline/alu_pipeline_wrapper.sv
tb/alu_pipeline_assert.sv
tb/alu_pipeline_tb.sv

// File: Bender.yml
package:
  name: alu_pipeline

export_include_dirs:
  - common

sources:
  - files:
      - common/core_types_pkg.sv
      - alu_pipeline/alu_operand_select.sv
      - alu_pipeline/alu_exec.sv
      - alu_pipeline/alu_pipeline.sv
      - alu_pipeline/alu_pipeline_wrapper.sv
  - target: test
    files:
      - tb/alu_pipeline_assert.sv
      - tb/alu_pipeline_tb.sv
